//--- vlog.f
logic/scaler_pkg.sv
logic/host_link_rx.sv
logic/mode_regs.sv
logic/umuldiv.sv
logic/ar_window.sv
logic/scaler_host_ctrl.sv
verif/scaler_host_ctrl_sva.sv
verif/tb_clkgen.sv
verif/tb_scaler_host_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_scaler_host_ctrl -f vlog.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation PASSED"; exit 0; }

//--- verif/tb_scaler_host_ctrl.sv
// Table-driven testbench for the scaler host control slice
// Host bus handshake driver, register model and window reference
// LFSR aspect cases, watchdog, per-test report lines
`timescale 1ns/100ps

module tb_scaler_host_ctrl import scaler_pkg::*;
();

localparam int SETTLE_CYC    = 130;
localparam int ACK_LIMIT     = 64;
localparam int CYC_PER_ENTRY = 400;
localparam int N_RAND        = 6;

localparam logic [1:0] K_WIN_FIX = 2'd0;
localparam logic [1:0] K_WIN_REF = 2'd1;
localparam logic [1:0] K_RB      = 2'd2;
localparam logic [7:0] OP_NONE   = 8'h00;

typedef struct packed {
	logic [1:0]       kind;
	logic [7:0]       opcode;
	logic [2:0]       nwords;
	logic [4:0][15:0] words;
	logic [12:0]      ar_x;
	logic [12:0]      ar_y;
	logic [3:0][15:0] expv;
} entry_t;

logic              clk_sys, resetd;
logic              io_clk, io_uio;
logic [HOST_W-1:0] io_din, io_dout;
logic [AR_W-1:0]   ar_x, ar_y;
logic              io_ack;
logic [DIM_W-1:0]  hmin, hmax, vmin, vmax;

entry_t      tbl[$];
int          n_entries = 0;
int          errors;
logic [31:0] lfsr;

// Register model
logic [11:0] m_width, m_height, m_vset, m_hset;
logic        m_free;
logic [12:0] m_arc [4];

tb_clkgen clkgen_i (
	.o_clk_sys (clk_sys),
	.o_resetd  (resetd)
);

scaler_host_ctrl scaler_host_ctrl_i (
	.clk_sys   (clk_sys),
	.resetd    (resetd),
	.i_io_clk  (io_clk),
	.i_io_uio  (io_uio),
	.i_io_din  (io_din),
	.i_ar_x    (ar_x),
	.i_ar_y    (ar_y),
	.o_io_ack  (io_ack),
	.o_io_dout (io_dout),
	.o_hmin    (hmin),
	.o_hmax    (hmax),
	.o_vmin    (vmin),
	.o_vmax    (vmax)
);

// Taps 32, 22, 2, 1
function automatic logic [7:0] rand_bits(input int n);
	logic [7:0] v;
	logic       fb;
	v = 8'd0;
	for (int i = 0; i < n; i++) begin
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		v    = {v[6:0], fb};
	end
	return v;
endfunction

function automatic void model_write(input logic [7:0] op, input int n,
	input logic [4:0][15:0] w);
	for (int i = 0; i < n; i++) begin
		case (op)
			OP_TIMING: begin
				if (i == 0)
					m_width = w[i][11:0];
				if (i == 4)
					m_height = w[i][11:0];
			end
			OP_VSET: m_vset = w[i][11:0];
			OP_HSET: begin
				m_hset = w[i][11:0];
				m_free = w[i][15];
			end
			OP_ARC: begin
				if (i < 4)
					m_arc[i] = w[i][12:0];
			end
			default: ;
		endcase
	end
endfunction

// Expected hmin, hmax, vmin, vmax in elements 0 to 3
function automatic logic [3:0][11:0] ref_window(input logic [12:0] ax, input logic [12:0] ay);
	logic [11:0]      ex, ey, ow, oh, wc, hc, vw, vh, ho, vo;
	logic             eabs;
	logic [23:0]      prod;
	logic [3:0][11:0] r;
	ex   = 12'd0;
	ey   = 12'd0;
	eabs = 1'b0;
	if (ay != 13'd0) begin
		ex   = ax[11:0];
		ey   = ay[11:0];
		eabs = ax[12] | ay[12];
	end
	else if (ax == 13'd1 || ax == 13'd2) begin
		ex   = m_arc[(ax == 13'd1) ? 0 : 2][11:0];
		ey   = m_arc[(ax == 13'd1) ? 1 : 3][11:0];
		eabs = m_arc[(ax == 13'd1) ? 0 : 2][12] | m_arc[(ax == 13'd1) ? 1 : 3][12];
	end
	oh = (m_vset != 12'd0 && m_vset < m_height) ? m_vset : m_height;
	ow = (m_hset != 12'd0 && m_hset < m_width) ? m_hset : m_width;
	if (m_free || ex == 12'd0 || ey == 12'd0) begin
		wc = ow;
		hc = oh;
	end
	else if (eabs) begin
		wc = ex;
		hc = ey;
	end
	else begin
		prod = {12'd0, oh} * {12'd0, ex};
		wc   = 12'(prod / {12'd0, ey});
		prod = {12'd0, ow} * {12'd0, ey};
		hc   = 12'(prod / {12'd0, ex});
	end
	vw   = (wc < ow) ? wc : ow;
	vh   = (hc < oh) ? hc : oh;
	ho   = (m_width - vw) >> 1;
	vo   = (m_height - vh) >> 1;
	r[0] = ho;
	r[1] = ho + vw - 12'd1;
	r[2] = vo;
	r[3] = vo + vh - 12'd1;
	return r;
endfunction

task automatic add_entry(input logic [1:0] kind, input logic [7:0] op, input int n,
	input logic [15:0] w0, input logic [15:0] w1, input logic [15:0] w2,
	input logic [15:0] w3, input logic [15:0] w4, input logic [12:0] ax,
	input logic [12:0] ay, input logic [15:0] e0, input logic [15:0] e1,
	input logic [15:0] e2, input logic [15:0] e3);
	entry_t e;
	e.kind   = kind;
	e.opcode = op;
	e.nwords = 3'(n);
	e.words  = {w4, w3, w2, w1, w0};
	e.ar_x   = ax;
	e.ar_y   = ay;
	e.expv   = {e3, e2, e1, e0};
	tbl.push_back(e);
endtask

task automatic wait_ack(input logic level);
	int n;
	n = 0;
	@(negedge clk_sys);
	while (io_ack !== level && n < ACK_LIMIT) begin
		@(negedge clk_sys);
		n++;
	end
	if (io_ack !== level) begin
		$display("Handshake stalled at %0t, acknowledge never went to %0b", $time, level);
		errors++;
	end
endtask

// Data is set up one cycle before the strobe rises
task automatic send_word(input logic [15:0] w, output logic [15:0] dout);
	@(posedge clk_sys);
	io_din <= w;
	@(posedge clk_sys);
	io_clk <= 1'b1;
	wait_ack(1'b1);
	dout = io_dout;
	@(posedge clk_sys);
	io_clk <= 1'b0;
	wait_ack(1'b0);
endtask

task automatic run_session(input logic [7:0] op, input int n, input logic [4:0][15:0] w,
	output logic [1:0][15:0] rb);
	logic [15:0] d;
	int          n_wait;
	rb = '0;
	@(posedge clk_sys);
	io_uio <= 1'b1;
	send_word({8'h00, op}, d);
	for (int i = 0; i < n; i++) begin
		send_word(w[i], d);
		if (i < 2)
			rb[i] = d;
	end
	@(posedge clk_sys);
	io_uio <= 1'b0;
	n_wait = 0;
	@(negedge clk_sys);
	while (io_dout !== 16'h0000 && n_wait < 8) begin
		@(negedge clk_sys);
		n_wait++;
	end
	if (io_dout !== 16'h0000) begin
		$display("Error: %0t: readback data still %h after the session ended", $time, io_dout);
		errors++;
	end
endtask

////////////////////
// Watchdog
initial begin
	wait (n_entries > 0);
	repeat (n_entries * CYC_PER_ENTRY) @(posedge clk_sys);
	$display("Run stopped by the watchdog after %0d cycles", n_entries * CYC_PER_ENTRY);
	$display("Test failed");
	$finish;
end

////////////////////
// Stimulus table and main loop
initial begin
	entry_t             e;
	logic [1:0][15:0]   rb;
	logic [3:0][11:0]   expw, got;
	logic [12:0]        ax, ay;
	int                 err_start;
	string              kind_name;
	$timeformat(-9, 0, " ns", 0);
	io_clk   <= 1'b0;
	io_uio   <= 1'b0;
	io_din   <= '0;
	ar_x     <= '0;
	ar_y     <= '0;
	errors   = 0;
	lfsr     = 32'he494_b7b5;
	m_width  = DEF_WIDTH;
	m_height = DEF_HEIGHT;
	m_vset   = 12'd0;
	m_hset   = 12'd0;
	m_free   = 1'b0;
	for (int i = 0; i < 4; i++)
		m_arc[i] = 13'd0;

	// Default frame and empty readback
	add_entry(K_WIN_FIX, OP_NONE, 0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'd0, 13'd0,
		16'd0, 16'd1919, 16'd0, 16'd1079);
	add_entry(K_RB, OP_READBACK, 0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'd0, 13'd0,
		16'h0000, 16'h0000, 16'd0, 16'd0);
	// Active size with dummy sync words, then 4:3
	add_entry(K_WIN_REF, OP_TIMING, 5, 16'd1280, 16'h0100, 16'h0200, 16'h0300, 16'd720,
		13'd4, 13'd3, 16'd0, 16'd0, 16'd0, 16'd0);
	add_entry(K_WIN_REF, OP_VSET, 1, 16'd600, 16'd0, 16'd0, 16'd0, 16'd0, 13'd4, 13'd3,
		16'd0, 16'd0, 16'd0, 16'd0);
	add_entry(K_WIN_REF, OP_HSET, 1, 16'd1000, 16'd0, 16'd0, 16'd0, 16'd0, 13'd4, 13'd3,
		16'd0, 16'd0, 16'd0, 16'd0);
	add_entry(K_WIN_REF, OP_HSET, 1, 16'h83E8, 16'd0, 16'd0, 16'd0, 16'd0, 13'd4, 13'd3,
		16'd0, 16'd0, 16'd0, 16'd0);
	add_entry(K_WIN_REF, OP_HSET, 1, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'd4, 13'd3,
		16'd0, 16'd0, 16'd0, 16'd0);
	add_entry(K_WIN_REF, OP_VSET, 1, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'd4, 13'd3,
		16'd0, 16'd0, 16'd0, 16'd0);
	// Custom ratios, the second one absolute
	add_entry(K_WIN_REF, OP_ARC, 4, 16'd5, 16'd4, 16'h1280, 16'h11E0, 16'd0, 13'd1, 13'd0,
		16'd0, 16'd0, 16'd0, 16'd0);
	add_entry(K_WIN_REF, OP_NONE, 0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'd2, 13'd0,
		16'd0, 16'd0, 16'd0, 16'd0);
	add_entry(K_RB, OP_READBACK, 0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'd2, 13'd0,
		16'h1280, 16'h11E0, 16'd0, 16'd0);
	add_entry(K_RB, OP_READBACK, 0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'd1, 13'd0,
		16'h0005, 16'h0004, 16'd0, 16'd0);
	add_entry(K_RB, OP_READBACK, 0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'h1320, 13'h0258,
		16'h1320, 16'h1258, 16'd0, 16'd0);
	add_entry(K_WIN_REF, OP_NONE, 0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, 13'h1320, 13'h0258,
		16'd0, 16'd0, 16'd0, 16'd0);
	// Ratios kept under 2:1 so no quotient wraps
	for (int i = 0; i < N_RAND; i++) begin
		ax = 13'd8 + 13'(rand_bits(3));
		ay = 13'd8 + 13'(rand_bits(3));
		add_entry(K_WIN_REF, OP_NONE, 0, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, ax, ay,
			16'd0, 16'd0, 16'd0, 16'd0);
	end
	n_entries = tbl.size();

	@(posedge clk_sys);
	while (resetd)
		@(posedge clk_sys);

	for (int t = 0; t < n_entries; t++) begin
		e         = tbl[t];
		err_start = errors;
		@(posedge clk_sys);
		ar_x <= e.ar_x;
		ar_y <= e.ar_y;
		if (e.kind == K_RB) begin
			kind_name = "readback";
			repeat (SETTLE_CYC) @(posedge clk_sys);
			run_session(OP_READBACK, 2, '0, rb);
			if (rb[0] !== e.expv[0] || rb[1] !== e.expv[1]) begin
				$display("Error: %0t: readback expected %h %h, got %h %h", $time,
					e.expv[0], e.expv[1], rb[0], rb[1]);
				errors++;
			end
		end
		else begin
			kind_name = "window";
			if (e.opcode != OP_NONE) begin
				run_session(e.opcode, int'(e.nwords), e.words, rb);
				model_write(e.opcode, int'(e.nwords), e.words);
			end
			repeat (SETTLE_CYC) @(posedge clk_sys);
			@(negedge clk_sys);
			if (e.kind == K_WIN_REF)
				expw = ref_window(e.ar_x, e.ar_y);
			else
				expw = {e.expv[3][11:0], e.expv[2][11:0], e.expv[1][11:0], e.expv[0][11:0]};
			got = {vmax, vmin, hmax, hmin};
			if (got !== expw) begin
				$display("Error: %0t: window expected %0d %0d %0d %0d, got %0d %0d %0d %0d",
					$time, expw[0], expw[1], expw[2], expw[3], hmin, hmax, vmin, vmax);
				errors++;
			end
		end
		if (errors == err_start)
			$display("Test %0d %s: ok", t, kind_name);
		else
			$display("Test %0d %s: mismatch", t, kind_name);
	end

	$display("Tests run: %0d, errors: %0d", n_entries, errors);
	if (errors == 0) begin
		$display("Test completed successfully");
	end
	else begin
		$display("Test failed");
	end
	$finish;
end

endmodule

//--- verif/tb_clkgen.sv
// Testbench clock and reset source
// 10 ns clock, reset held high for three cycles
`timescale 1ns/100ps

module tb_clkgen (
	output logic o_clk_sys,
	output logic o_resetd
);

initial begin
	o_clk_sys = 1'b0;
	forever #5 o_clk_sys = ~o_clk_sys;
end

initial begin
	o_resetd = 1'b1;
	repeat (3) @(posedge o_clk_sys);
	o_resetd <= 1'b0;
end

endmodule

//--- verif/scaler_host_ctrl_sva.sv
// Concurrent checks bound into the host control top level
// Acknowledge after reset, window bound order, multiply-divide busy length
`timescale 1ns/100ps

module scaler_host_ctrl_sva import scaler_pkg::*;
(
	input logic             clk_sys,
	input logic             resetd,
	input logic             i_io_ack,
	input logic [DIM_W-1:0] i_hmin,
	input logic [DIM_W-1:0] i_hmax,
	input logic             i_md_busy
);

logic [7:0] busy_cnt;

// Length of the current busy run
always_ff @(posedge clk_sys) begin
	if (resetd)
		busy_cnt <= 8'd0;
	else if (i_md_busy)
		busy_cnt <= busy_cnt + 8'd1;
	else
		busy_cnt <= 8'd0;
end

ack_low_after_reset: assert property (@(posedge clk_sys) resetd |=> !i_io_ack)
	else $error("acknowledge high in the cycle after reset");

hmin_not_above_hmax: assert property (@(posedge clk_sys) disable iff (resetd)
	(i_hmax != '0) |-> (i_hmin <= i_hmax))
	else $error("window hmin above hmax");

busy_run_short: assert property (@(posedge clk_sys) disable iff (resetd)
	busy_cnt < 8'd64)
	else $error("multiply-divide busy for 64 cycles or more");

endmodule

bind scaler_host_ctrl scaler_host_ctrl_sva scaler_host_ctrl_sva_i (
	.clk_sys   (clk_sys),
	.resetd    (resetd),
	.i_io_ack  (o_io_ack),
	.i_hmin    (o_hmin),
	.i_hmax    (o_hmax),
	.i_md_busy (ar_window_i.md_busy)
);

//--- logic/scaler_host_ctrl.sv
// Host command slice of the scaler control
// Receiver, mode register stage and window stage
`timescale 1ns/100ps

module scaler_host_ctrl import scaler_pkg::*;
(
	input  logic              clk_sys,
	input  logic              resetd,

	input  logic              i_io_clk,
	input  logic              i_io_uio,
	input  logic [HOST_W-1:0] i_io_din,
	input  logic [AR_W-1:0]   i_ar_x,
	input  logic [AR_W-1:0]   i_ar_y,

	output logic              o_io_ack,
	output logic [HOST_W-1:0] o_io_dout,
	output logic [DIM_W-1:0]  o_hmin,
	output logic [DIM_W-1:0]  o_hmax,
	output logic [DIM_W-1:0]  o_vmin,
	output logic [DIM_W-1:0]  o_vmax
);

logic             wr, first, uio_sync;
logic [7:0]       opcode, idx;
host_word_u       word;
logic [DIM_W-1:0] width, height, vset, hset;
logic             freescale;
logic [AR_W-1:0]  arc1x, arc1y, arc2x, arc2y;
logic [DIM_W-1:0] eff_x, eff_y;
logic             eff_abs;

host_link_rx host_link_rx_i (
	.clk_sys    (clk_sys),
	.resetd     (resetd),
	.i_io_clk   (i_io_clk),
	.i_io_uio   (i_io_uio),
	.i_io_din   (i_io_din),
	.o_io_ack   (o_io_ack),
	.o_uio_sync (uio_sync),
	.o_wr       (wr),
	.o_opcode   (opcode),
	.o_idx      (idx),
	.o_first    (first),
	.o_word     (word)
);

mode_regs mode_regs_i (
	.clk_sys     (clk_sys),
	.resetd      (resetd),
	.i_wr        (wr),
	.i_opcode    (opcode),
	.i_idx       (idx),
	.i_first     (first),
	.i_word      (word),
	.i_uio_sync  (uio_sync),
	.i_eff_x     (eff_x),
	.i_eff_y     (eff_y),
	.i_eff_abs   (eff_abs),
	.o_width     (width),
	.o_height    (height),
	.o_vset      (vset),
	.o_hset      (hset),
	.o_freescale (freescale),
	.o_arc1x     (arc1x),
	.o_arc1y     (arc1y),
	.o_arc2x     (arc2x),
	.o_arc2y     (arc2y),
	.o_io_dout   (o_io_dout)
);

ar_window ar_window_i (
	.clk_sys     (clk_sys),
	.resetd      (resetd),
	.i_width     (width),
	.i_height    (height),
	.i_vset      (vset),
	.i_hset      (hset),
	.i_freescale (freescale),
	.i_ar_x      (i_ar_x),
	.i_ar_y      (i_ar_y),
	.i_arc1x     (arc1x),
	.i_arc1y     (arc1y),
	.i_arc2x     (arc2x),
	.i_arc2y     (arc2y),
	.o_eff_x     (eff_x),
	.o_eff_y     (eff_y),
	.o_eff_abs   (eff_abs),
	.o_hmin      (o_hmin),
	.o_hmax      (o_hmax),
	.o_vmin      (o_vmin),
	.o_vmax      (o_vmax)
);

endmodule

//--- logic/ar_window.sv
// Aspect ratio window calculation
// Effective aspect select, output size clamp
// Eight-state loop computing the centered window bounds
`timescale 1ns/100ps

module ar_window import scaler_pkg::*;
(
	input  logic             clk_sys,
	input  logic             resetd,

	input  logic [DIM_W-1:0] i_width,
	input  logic [DIM_W-1:0] i_height,
	input  logic [DIM_W-1:0] i_vset,
	input  logic [DIM_W-1:0] i_hset,
	input  logic             i_freescale,
	input  logic [AR_W-1:0]  i_ar_x,
	input  logic [AR_W-1:0]  i_ar_y,
	input  logic [AR_W-1:0]  i_arc1x,
	input  logic [AR_W-1:0]  i_arc1y,
	input  logic [AR_W-1:0]  i_arc2x,
	input  logic [AR_W-1:0]  i_arc2y,

	output logic [DIM_W-1:0] o_eff_x,
	output logic [DIM_W-1:0] o_eff_y,
	output logic             o_eff_abs,
	output logic [DIM_W-1:0] o_hmin,
	output logic [DIM_W-1:0] o_hmax,
	output logic [DIM_W-1:0] o_vmin,
	output logic [DIM_W-1:0] o_vmax
);

logic [DIM_W-1:0] out_w, out_h;
logic [DIM_W-1:0] wcalc, hcalc;
logic [DIM_W-1:0] videow, videoh;
logic [DIM_W-1:0] hoff, voff;
logic [DIM_W-1:0] md_mul1, md_mul2, md_div, md_res;
logic             md_start, md_busy;
logic [2:0]       state;

umuldiv umuldiv_i (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.i_start  (md_start),
	.i_mul1   (md_mul1),
	.i_mul2   (md_mul2),
	.i_div    (md_div),
	.o_busy   (md_busy),
	.o_result (md_res)
);

assign hoff = (i_width - videow) >> 1;
assign voff = (i_height - videoh) >> 1;

////////////////////
// Effective aspect
always_ff @(posedge clk_sys) begin
	if (resetd) begin
		o_eff_x   <= '0;
		o_eff_y   <= '0;
		o_eff_abs <= 1'b0;
	end
	else if (i_ar_y != '0) begin
		o_eff_x   <= i_ar_x[DIM_W-1:0];
		o_eff_y   <= i_ar_y[DIM_W-1:0];
		o_eff_abs <= i_ar_x[AR_W-1] | i_ar_y[AR_W-1];
	end
	else if (i_ar_x == AR_W'(1)) begin
		o_eff_x   <= i_arc1x[DIM_W-1:0];
		o_eff_y   <= i_arc1y[DIM_W-1:0];
		o_eff_abs <= i_arc1x[AR_W-1] | i_arc1y[AR_W-1];
	end
	else if (i_ar_x == AR_W'(2)) begin
		o_eff_x   <= i_arc2x[DIM_W-1:0];
		o_eff_y   <= i_arc2y[DIM_W-1:0];
		o_eff_abs <= i_arc2x[AR_W-1] | i_arc2y[AR_W-1];
	end
	else begin
		o_eff_x   <= '0;
		o_eff_y   <= '0;
		o_eff_abs <= 1'b0;
	end
end

// Size limits apply only below the active size
always_ff @(posedge clk_sys) begin
	out_h <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
	out_w <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
end

////////////////////
// Window loop
always_ff @(posedge clk_sys) begin
	if (resetd) begin
		state    <= 3'd0;
		md_start <= 1'b0;
		o_hmin   <= '0;
		o_hmax   <= '0;
		o_vmin   <= '0;
		o_vmax   <= '0;
	end
	else begin
		md_start <= 1'b0;
		state    <= state + 3'd1;
		case (state)
			3'd0: begin
				if (i_freescale || o_eff_x == '0 || o_eff_y == '0) begin
					wcalc <= out_w;
					hcalc <= out_h;
					state <= 3'd6;
				end
				else if (o_eff_abs) begin
					wcalc <= o_eff_x;
					hcalc <= o_eff_y;
					state <= 3'd6;
				end
			end
			// Width from height
			3'd1: begin
				md_mul1  <= out_h;
				md_mul2  <= o_eff_x;
				md_div   <= o_eff_y;
				md_start <= 1'b1;
			end
			3'd2: begin
				wcalc <= md_res;
				if (md_start | md_busy)
					state <= 3'd2;
			end
			// Height from width
			3'd3: begin
				md_mul1  <= out_w;
				md_mul2  <= o_eff_y;
				md_div   <= o_eff_x;
				md_start <= 1'b1;
			end
			3'd4: begin
				hcalc <= md_res;
				if (md_start | md_busy)
					state <= 3'd4;
			end
			3'd6: begin
				videow <= (wcalc > out_w) ? out_w : wcalc;
				videoh <= (hcalc > out_h) ? out_h : hcalc;
			end
			3'd7: begin
				o_hmin <= hoff;
				o_hmax <= hoff + videow - 12'd1;
				o_vmin <= voff;
				o_vmax <= voff + videoh - 12'd1;
			end
			default: ;
		endcase
	end
end

endmodule

//--- logic/umuldiv.sv
// Sequential unsigned multiply then divide
// Shift-and-add product, restoring division, two steps per clock
`timescale 1ns/100ps

module umuldiv import scaler_pkg::*;
(
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_start,
	input  logic [DIM_W-1:0] i_mul1,
	input  logic [DIM_W-1:0] i_mul2,
	input  logic [DIM_W-1:0] i_div,
	output logic             o_busy,
	output logic [DIM_W-1:0] o_result
);

logic [PROD_W-1:0] acc, mcand, quo;
logic [PROD_W-1:0] acc_1, acc_2;
logic [DIM_W-1:0]  mplier, divisor, rem;
logic [DIM_W:0]    step_1, step_2;
logic [3:0]        cnt;
logic              div_phase;

// One restoring step, quotient bit on top of the new remainder
function automatic logic [DIM_W:0] restore_step(
	input logic [DIM_W-1:0] r,
	input logic             b,
	input logic [DIM_W-1:0] d
);
	logic [DIM_W:0] sh;
	logic [DIM_W:0] diff;
	sh   = {r, b};
	diff = sh - {1'b0, d};
	if (sh >= {1'b0, d})
		return {1'b1, diff[DIM_W-1:0]};
	return {1'b0, sh[DIM_W-1:0]};
endfunction

assign acc_1  = mplier[0] ? acc + mcand : acc;
assign acc_2  = mplier[1] ? acc_1 + (mcand << 1) : acc_1;
assign step_1 = restore_step(rem, quo[PROD_W-1], divisor);
assign step_2 = restore_step(step_1[DIM_W-1:0], quo[PROD_W-2], divisor);

assign o_result = quo[DIM_W-1:0];

always_ff @(posedge clk_sys) begin
	if (resetd) begin
		o_busy    <= 1'b0;
		div_phase <= 1'b0;
		cnt       <= 4'd0;
	end
	else if (i_start) begin
		o_busy    <= 1'b1;
		div_phase <= 1'b0;
		cnt       <= 4'd0;
		acc       <= '0;
		mcand     <= {{(PROD_W-DIM_W){1'b0}}, i_mul1};
		mplier    <= i_mul2;
		divisor   <= i_div;
	end
	else if (o_busy) begin
		cnt <= cnt + 4'd1;
		if (!div_phase) begin
			acc    <= acc_2;
			mcand  <= mcand << 2;
			mplier <= mplier >> 2;
			if (cnt == 4'(MD_MUL_CYC - 1)) begin
				quo       <= acc_2;
				rem       <= '0;
				div_phase <= 1'b1;
				cnt       <= 4'd0;
			end
		end
		else begin
			rem <= step_2[DIM_W-1:0];
			quo <= {quo[PROD_W-3:0], step_1[DIM_W], step_2[DIM_W]};
			if (cnt == 4'(MD_DIV_CYC - 1)) begin
				o_busy    <= 1'b0;
				div_phase <= 1'b0;
			end
		end
	end
end

endmodule

//--- logic/mode_regs.sv
// Video mode registers written by host data words
// Active size, size limits, free-scale flag, custom aspect ratios
// Readback of the effective aspect ratio
`timescale 1ns/100ps

module mode_regs import scaler_pkg::*;
(
	input  logic              clk_sys,
	input  logic              resetd,

	input  logic              i_wr,
	input  logic [7:0]        i_opcode,
	input  logic [7:0]        i_idx,
	input  logic              i_first,
	input  host_word_u        i_word,
	input  logic              i_uio_sync,

	input  logic [DIM_W-1:0]  i_eff_x,
	input  logic [DIM_W-1:0]  i_eff_y,
	input  logic              i_eff_abs,

	output logic [DIM_W-1:0]  o_width,
	output logic [DIM_W-1:0]  o_height,
	output logic [DIM_W-1:0]  o_vset,
	output logic [DIM_W-1:0]  o_hset,
	output logic              o_freescale,
	output logic [AR_W-1:0]   o_arc1x,
	output logic [AR_W-1:0]   o_arc1y,
	output logic [AR_W-1:0]   o_arc2x,
	output logic [AR_W-1:0]   o_arc2y,
	output logic [HOST_W-1:0] o_io_dout
);

logic [HOST_W-1:0] rb_x;
logic [HOST_W-1:0] rb_y;

// Value in the low bits, absolute flag above it
assign rb_x = {{(HOST_W-DIM_W-1){1'b0}}, i_eff_abs, i_eff_x};
assign rb_y = {{(HOST_W-DIM_W-1){1'b0}}, i_eff_abs, i_eff_y};

always_ff @(posedge clk_sys) begin
	if (resetd) begin
		o_width     <= DEF_WIDTH;
		o_height    <= DEF_HEIGHT;
		o_vset      <= '0;
		o_hset      <= '0;
		o_freescale <= 1'b0;
		o_arc1x     <= '0;
		o_arc1y     <= '0;
		o_arc2x     <= '0;
		o_arc2y     <= '0;
		o_io_dout   <= '0;
	end
	else if (!i_uio_sync) begin
		o_io_dout <= '0;
	end
	else if (i_wr) begin
		o_io_dout <= '0;
		if (!i_first) begin
			case (i_opcode)
				// Sync and blanking words are skipped
				OP_TIMING: begin
					if (i_idx == IDX_WIDTH)
						o_width <= i_word.fld.value;
					if (i_idx == IDX_HEIGHT)
						o_height <= i_word.fld.value;
				end
				OP_VSET: begin
					o_vset <= i_word.fld.value;
				end
				OP_HSET: begin
					o_hset      <= i_word.fld.value;
					o_freescale <= i_word.fld.flag;
				end
				OP_ARC: begin
					case (i_idx)
						8'd0: o_arc1x <= i_word.raw[AR_W-1:0];
						8'd1: o_arc1y <= i_word.raw[AR_W-1:0];
						8'd2: o_arc2x <= i_word.raw[AR_W-1:0];
						8'd3: o_arc2y <= i_word.raw[AR_W-1:0];
						default: ;
					endcase
				end
				OP_READBACK: begin
					if (i_idx == 8'd0)
						o_io_dout <= rb_x;
					if (i_idx == 8'd1)
						o_io_dout <= rb_y;
				end
				default: ;
			endcase
		end
	end
end

endmodule

//--- logic/host_link_rx.sv
// Host bus receiver
// Two-stage input synchronizers, strobe detect, toggle acknowledge
// Command and data word framing with word index
`timescale 1ns/100ps

module host_link_rx import scaler_pkg::*;
(
	input  logic       clk_sys,
	input  logic       resetd,

	input  logic       i_io_clk,
	input  logic       i_io_uio,
	input  host_word_u i_io_din,
	output logic       o_io_ack,
	output logic       o_uio_sync,

	output logic       o_wr,
	output logic [7:0] o_opcode,
	output logic [7:0] o_idx,
	output logic       o_first,
	output host_word_u o_word
);

host_word_u din_s1;
host_word_u din_s2;
logic       clk_s1, clk_s2;
logic       uio_s1, uio_s2;
logic       rack;
logic       ack_q;
logic       strobe;
logic       has_cmd;
logic [7:0] cmd;
logic [7:0] cnt;

assign strobe     = clk_s2 & ~rack;
assign o_io_ack   = ack_q;
assign o_uio_sync = uio_s2;

// Data is stable while the strobe is high
always_ff @(posedge clk_sys) begin
	din_s1 <= i_io_din;
	din_s2 <= din_s1;
	o_word <= din_s2;
end

always_ff @(posedge clk_sys) begin
	if (resetd) begin
		clk_s1   <= 1'b0;
		clk_s2   <= 1'b0;
		uio_s1   <= 1'b0;
		uio_s2   <= 1'b0;
		rack     <= 1'b0;
		ack_q    <= 1'b0;
		has_cmd  <= 1'b0;
		cmd      <= 8'd0;
		cnt      <= 8'd0;
		o_wr     <= 1'b0;
		o_first  <= 1'b0;
		o_opcode <= 8'd0;
		o_idx    <= 8'd0;
	end
	else begin
		clk_s1 <= i_io_clk;
		clk_s2 <= clk_s1;
		uio_s1 <= i_io_uio;
		uio_s2 <= uio_s1;

		// Extra stage lines the ack up with readback data
		rack  <= clk_s2;
		ack_q <= rack;

		o_wr <= strobe & uio_s2;

		if (!uio_s2) begin
			has_cmd <= 1'b0;
			cmd     <= 8'd0;
			cnt     <= 8'd0;
		end
		else if (strobe) begin
			o_first <= ~has_cmd;
			if (!has_cmd) begin
				// First word of a session is the command
				has_cmd  <= 1'b1;
				cmd      <= din_s2.cmd.opcode;
				cnt      <= 8'd0;
				o_opcode <= din_s2.cmd.opcode;
				o_idx    <= 8'd0;
			end
			else begin
				cnt      <= cnt + 8'd1;
				o_opcode <= cmd;
				o_idx    <= cnt;
			end
		end
	end
end

endmodule

//--- logic/scaler_pkg.sv
// Shared widths, host opcodes and word indices
// Reset defaults for the video mode
// Host word union with command, field and raw views
package scaler_pkg;

	localparam int HOST_W = 16;
	localparam int DIM_W  = 12;
	// Top bit of an aspect field marks an absolute size
	localparam int AR_W   = 13;

	// Multiply-divide sizing, two steps per clock
	localparam int PROD_W     = 2 * DIM_W;
	localparam int MD_MUL_CYC = DIM_W / 2;
	localparam int MD_DIV_CYC = PROD_W / 2;

	localparam logic [7:0] OP_TIMING   = 8'h20;
	localparam logic [7:0] OP_VSET     = 8'h27;
	localparam logic [7:0] OP_HSET     = 8'h37;
	localparam logic [7:0] OP_ARC      = 8'h3A;
	localparam logic [7:0] OP_READBACK = 8'h40;

	localparam logic [7:0] IDX_WIDTH  = 8'd0;
	localparam logic [7:0] IDX_HEIGHT = 8'd4;

	localparam logic [DIM_W-1:0] DEF_WIDTH  = 12'd1920;
	localparam logic [DIM_W-1:0] DEF_HEIGHT = 12'd1080;

	typedef union packed {
		struct packed {
			logic [7:0] rsvd;
			logic [7:0] opcode;
		} cmd;
		struct packed {
			logic             flag;
			logic [2:0]       rsvd;
			logic [DIM_W-1:0] value;
		} fld;
		logic [HOST_W-1:0] raw;
	} host_word_u;

endpackage
